// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_img_capture
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES   := $(shell grep -v '^+' $(FILELIST))
BIN       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := Simulation finished: PASS

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: list.f
logic/img_pkg.sv
logic/frame_scanner.sv
logic/pixel_stats.sv
logic/fletcher_checksum.sv
logic/readout_framer.sv
logic/img_capture_top.sv
verification/img_checker.sv
verification/tb_img_capture.sv

// File: logic/fletcher_checksum.sv
`default_nettype none

module fletcher_checksum
    import img_pkg::*;
(
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire                   clear,
    input  wire pixel_beat_t      beat,
    output logic [2*WORD_BITS-1:0] sum
);

    logic [WORD_BITS-1:0] sum1;
    logic [WORD_BITS-1:0] sum2;
    logic [WORD_BITS-1:0] sum1_next;
    logic [WORD_BITS-1:0] sum2_next;

    // Add modulo 65535, one subtraction is enough for two 16-bit operands
    function automatic logic [WORD_BITS-1:0] mod_add(input logic [WORD_BITS-1:0] a,
                                                     input logic [WORD_BITS-1:0] b);
        logic [WORD_BITS:0] s;
        s = a + b;
        if (s >= (WORD_BITS+1)'(FLETCHER_MOD)) begin
            s = s - (WORD_BITS+1)'(FLETCHER_MOD);
        end
        return s[WORD_BITS-1:0];
    endfunction

    assign sum1_next = mod_add(sum1, beat.word);
    assign sum2_next = mod_add(sum2, sum1_next);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sum1 <= '0;
            sum2 <= '0;
        end else if (clear) begin
            sum1 <= '0;
            sum2 <= '0;
        end else if (beat.keep) begin
            sum1 <= sum1_next;
            sum2 <= sum2_next;
        end
    end

    assign sum = {sum2, sum1};

    assert property (@(posedge clk) disable iff (!arst_n)
        (sum1 != FLETCHER_MOD) && (sum2 != FLETCHER_MOD))
        else $error("fletcher_checksum: sum left its modulo range");

endmodule

`default_nettype wire

// File: logic/frame_scanner.sv
`default_nettype none

module frame_scanner
    import img_pkg::*;
(
    input  wire               clk,
    input  wire               arst_n,
    input  wire               arm,
    input  wire capture_cmd_t cmd,
    input  wire pixel_in_t    img,
    output pixel_beat_t       beat
);

    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_WAIT    = 2'd1;
    localparam logic [1:0] ST_CAPTURE = 2'd2;

    pixel_in_t                  pin_q;
    logic                       fv_prev;
    logic                       lv_prev;
    logic [1:0]                 state;
    logic [SKIP_BITS-1:0]       skip_cnt;
    logic                       thumb;
    logic [THUMB_GRID_BITS-1:0] x_cnt;
    logic [THUMB_GRID_BITS-1:0] y_cnt;
    logic                       fv_rise;
    logic                       cap_start;
    logic                       cap_end;
    logic                       pix_valid;
    logic                       on_grid;
    logic                       in_thumb;
    logic                       keep_q;
    logic                       sample_q;
    logic                       done_q;
    logic [WORD_BITS-1:0]       word_q;
    logic [TONE_BITS-1:0]       tone_q;

    // ==================================================
    // Input register stage and edge history
    // ==================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pin_q   <= '0;
            fv_prev <= 1'b0;
            lv_prev <= 1'b0;
        end else begin
            pin_q   <= img;
            fv_prev <= pin_q.fv;
            lv_prev <= pin_q.lv;
        end
    end

    assign fv_rise   = pin_q.fv && !fv_prev;
    // Last skip frame already passed, so this rise opens the captured frame
    assign cap_start = (state == ST_WAIT) && fv_rise && (skip_cnt == '0);
    assign cap_end   = (state == ST_CAPTURE) && !pin_q.fv;
    assign pix_valid = pin_q.lv && (cap_start || ((state == ST_CAPTURE) && pin_q.fv));

    assign on_grid  = (x_cnt[STAT_GRID_BITS-1:0] == '0) && (y_cnt[STAT_GRID_BITS-1:0] == '0);
    assign in_thumb = (x_cnt < THUMB_GRID_BITS'(THUMB_KEEP)) &&
                      (y_cnt < THUMB_GRID_BITS'(THUMB_KEEP));

    // Only the low bits of the position matter, so the counters wrap freely
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            x_cnt <= '0;
            y_cnt <= '0;
        end else begin
            x_cnt <= pin_q.lv ? x_cnt + 1'b1 : '0;
            if (!pin_q.fv) begin
                y_cnt <= '0;
            end else if (lv_prev && !pin_q.lv) begin
                y_cnt <= y_cnt + 1'b1;
            end
        end
    end

    // ==================================================
    // Capture FSM
    // ==================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= ST_IDLE;
            skip_cnt <= '0;
            thumb    <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (arm) begin
                        skip_cnt <= cmd.skip;
                        thumb    <= cmd.thumb;
                        state    <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (fv_rise) begin
                        if (skip_cnt != '0) begin
                            skip_cnt <= skip_cnt - 1'b1;
                        end else begin
                            state <= ST_CAPTURE;
                        end
                    end
                end
                ST_CAPTURE: begin
                    if (!pin_q.fv) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Beat flags
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            keep_q   <= 1'b0;
            sample_q <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            keep_q   <= pix_valid && (!thumb || in_thumb);
            sample_q <= pix_valid && on_grid;
            done_q   <= cap_end;
        end
    end

    // Little-endian word, low byte first
    always_ff @(posedge clk) begin
        word_q <= {pin_q.d[7:0], {(WORD_BITS - PIXEL_BITS){1'b0}}, pin_q.d[PIXEL_BITS-1:8]};
        tone_q <= pin_q.d[PIXEL_BITS-1 -: TONE_BITS];
    end

    assign beat = '{keep: keep_q, word: word_q, sample: sample_q, tone: tone_q,
                    frame_done: done_q};

    // The framer arms once per start and holds busy until the trailer is out
    assert property (@(posedge clk) disable iff (!arst_n) arm |-> state == ST_IDLE)
        else $error("frame_scanner: arm received during a capture");

endmodule

`default_nettype wire

// File: logic/img_capture_top.sv
`default_nettype none

module img_capture_top
    import img_pkg::*;
#(
    parameter int HEADER_WORDS = 4
) (
    input  wire                              clk,
    input  wire                              arst_n,
    input  wire                              start,
    input  wire capture_cmd_t                cmd,
    input  wire [HEADER_WORDS*WORD_BITS-1:0] header,
    input  wire pixel_in_t                   img,
    output readout_t                         out,
    output logic                             busy
);

    pixel_beat_t            beat;
    frame_stats_t           stats;
    logic [2*WORD_BITS-1:0] sum;
    logic                   arm;
    capture_cmd_t           arm_cmd;
    logic                   clear;

    // ==================================================
    // Pixel path
    // ==================================================
    frame_scanner u_scanner (
        .clk    (clk),
        .arst_n (arst_n),
        .arm    (arm),
        .cmd    (arm_cmd),
        .img    (img),
        .beat   (beat)
    );

    pixel_stats u_stats (
        .clk    (clk),
        .arst_n (arst_n),
        .clear  (clear),
        .beat   (beat),
        .stats  (stats)
    );

    fletcher_checksum u_checksum (
        .clk    (clk),
        .arst_n (arst_n),
        .clear  (clear),
        .beat   (beat),
        .sum    (sum)
    );

    // Output sequencing
    readout_framer #(
        .HEADER_WORDS (HEADER_WORDS)
    ) u_framer (
        .clk     (clk),
        .arst_n  (arst_n),
        .start   (start),
        .cmd     (cmd),
        .header  (header),
        .beat    (beat),
        .stats   (stats),
        .sum     (sum),
        .arm     (arm),
        .arm_cmd (arm_cmd),
        .clear   (clear),
        .out     (out),
        .busy    (busy)
    );

endmodule

`default_nettype wire

// File: logic/img_pkg.sv
`default_nettype none

package img_pkg;

    // ==================================================
    // Sizes and encodings
    // ==================================================
    localparam int PIXEL_BITS      = 12;
    localparam int WORD_BITS       = 16;
    localparam int SKIP_BITS       = 2;
    localparam int TONE_BITS       = 7;

    // Sample grid is every 4th pixel in x and y
    localparam int STAT_GRID_BITS  = 2;

    // Thumbnail keeps the upper-left 2x2 of each 8x8 block
    localparam int THUMB_GRID_BITS = 3;
    localparam int THUMB_KEEP      = 2;

    // Highlight, shadow, checksum low word, checksum high word
    localparam int TRAILER_WORDS   = 4;
    localparam int unsigned FLETCHER_MOD = 65535;

    // ==================================================
    // Shared types
    // ==================================================
    typedef struct packed {
        logic [SKIP_BITS-1:0] skip;
        logic                 thumb;
    } capture_cmd_t;

    typedef struct packed {
        logic                  fv;
        logic                  lv;
        logic [PIXEL_BITS-1:0] d;
    } pixel_in_t;

    // One scanner output cycle
    typedef struct packed {
        logic                 keep;
        logic [WORD_BITS-1:0] word;
        logic                 sample;
        logic [TONE_BITS-1:0] tone;
        logic                 frame_done;
    } pixel_beat_t;

    typedef struct packed {
        logic [WORD_BITS-1:0] highlight;
        logic [WORD_BITS-1:0] shadow;
    } frame_stats_t;

    typedef struct packed {
        logic                 valid;
        logic [WORD_BITS-1:0] data;
    } readout_t;

endpackage

`default_nettype wire

// File: logic/pixel_stats.sv
`default_nettype none

module pixel_stats
    import img_pkg::*;
(
    input  wire              clk,
    input  wire              arst_n,
    input  wire              clear,
    input  wire pixel_beat_t beat,
    output frame_stats_t     stats
);

    // Sample pixels count in thumbnail mode too, kept or not
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stats <= '0;
        end else if (clear) begin
            stats <= '0;
        end else if (beat.sample) begin
            // All top bits set means highlight
            if (&beat.tone) begin
                stats.highlight <= stats.highlight + 1'b1;
            end
            // All top bits clear means shadow
            if (~|beat.tone) begin
                stats.shadow <= stats.shadow + 1'b1;
            end
        end
    end

    // A frame never has enough sample pixels to fill a count
    assert property (@(posedge clk) disable iff (!arst_n)
        (!clear && beat.sample) |-> (stats.highlight != '1) && (stats.shadow != '1))
        else $error("pixel_stats: tone count about to wrap");

endmodule

`default_nettype wire

// File: logic/readout_framer.sv
`default_nettype none

module readout_framer
    import img_pkg::*;
#(
    parameter int HEADER_WORDS = 4
) (
    input  wire                                clk,
    input  wire                                arst_n,
    input  wire                                start,
    input  wire capture_cmd_t                  cmd,
    input  wire [HEADER_WORDS*WORD_BITS-1:0]   header,
    input  wire pixel_beat_t                   beat,
    input  wire frame_stats_t                  stats,
    input  wire [2*WORD_BITS-1:0]              sum,
    output logic                               arm,
    output capture_cmd_t                       arm_cmd,
    output logic                               clear,
    output readout_t                           out,
    output logic                               busy
);

    // Header and trailer share one shift register
    localparam int SHIFT_WORDS = (HEADER_WORDS > TRAILER_WORDS) ? HEADER_WORDS : TRAILER_WORDS;
    localparam int SHIFT_BITS  = SHIFT_WORDS * WORD_BITS;
    localparam int CNT_BITS    = $clog2(SHIFT_WORDS + 1);

    localparam logic [2:0] ST_IDLE    = 3'd0;
    localparam logic [2:0] ST_HEADER  = 3'd1;
    localparam logic [2:0] ST_PIXELS  = 3'd2;
    localparam logic [2:0] ST_SETTLE  = 3'd3;
    localparam logic [2:0] ST_TRAILER = 3'd4;

    logic [2:0]                         state;
    logic [SHIFT_BITS-1:0]              shift_q;
    logic [CNT_BITS-1:0]                words_left;
    logic [SHIFT_BITS-1:0]              header_ext;
    logic [TRAILER_WORDS*WORD_BITS-1:0] trailer;
    logic [SHIFT_BITS-1:0]              trailer_ext;

    // Left-align so the first word sits in the top bits
    assign header_ext  = SHIFT_BITS'(header) << (SHIFT_BITS - HEADER_WORDS*WORD_BITS);
    assign trailer     = {stats.highlight, stats.shadow,
                          sum[WORD_BITS-1:0], sum[2*WORD_BITS-1:WORD_BITS]};
    assign trailer_ext = SHIFT_BITS'(trailer) << (SHIFT_BITS - TRAILER_WORDS*WORD_BITS);

    // ==================================================
    // Readout FSM
    // ==================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= ST_IDLE;
            shift_q    <= '0;
            words_left <= '0;
            arm        <= 1'b0;
            arm_cmd    <= '0;
            clear      <= 1'b0;
            out        <= '0;
            busy       <= 1'b0;
        end else begin
            arm       <= 1'b0;
            clear     <= 1'b0;
            out.valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        arm_cmd    <= cmd;
                        clear      <= 1'b1;
                        busy       <= 1'b1;
                        out.valid  <= 1'b1;
                        out.data   <= header_ext[SHIFT_BITS-1 -: WORD_BITS];
                        shift_q    <= header_ext << WORD_BITS;
                        words_left <= CNT_BITS'(HEADER_WORDS - 1);
                        arm        <= (HEADER_WORDS == 1);
                        state      <= ST_HEADER;
                    end
                end
                ST_HEADER, ST_TRAILER: begin
                    if (words_left != '0) begin
                        out.valid  <= 1'b1;
                        out.data   <= shift_q[SHIFT_BITS-1 -: WORD_BITS];
                        shift_q    <= shift_q << WORD_BITS;
                        words_left <= words_left - 1'b1;
                        // Arm lands with the last header word
                        arm        <= (state == ST_HEADER) && (words_left == CNT_BITS'(1));
                    end else if (state == ST_HEADER) begin
                        state <= ST_PIXELS;
                    end else begin
                        busy  <= 1'b0;
                        state <= ST_IDLE;
                    end
                end
                ST_PIXELS: begin
                    out.valid <= beat.keep;
                    out.data  <= beat.word;
                    if (beat.frame_done) begin
                        state <= ST_SETTLE;
                    end
                end
                ST_SETTLE: begin
                    // Stats and checksum have taken the last beat by now
                    out.valid  <= 1'b1;
                    out.data   <= trailer_ext[SHIFT_BITS-1 -: WORD_BITS];
                    shift_q    <= trailer_ext << WORD_BITS;
                    words_left <= CNT_BITS'(TRAILER_WORDS - 1);
                    state      <= ST_TRAILER;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Scanner must stay quiet while fixed words occupy the output
    assert property (@(posedge clk) disable iff (!arst_n)
        ((state == ST_HEADER) || (state == ST_TRAILER)) |-> !beat.keep)
        else $error("readout_framer: pixel beat during header or trailer");

endmodule

`default_nettype wire

// File: verification/img_checker.sv
`default_nettype none

module img_checker
    import img_pkg::*;
#(
    parameter int HEADER_WORDS = 4,
    parameter int FRAME_W      = 16,
    parameter int FRAME_H      = 12
) (
    input wire                              clk,
    input wire                              arst_n,
    input wire                              start,
    input wire capture_cmd_t                cmd,
    input wire [HEADER_WORDS*WORD_BITS-1:0] header,
    input wire pixel_in_t                   img,
    input wire readout_t                    out,
    input wire                              busy
);

    string test_name = "reset";
    string cap_name  = "reset";
    int    errors    = 0;
    int    captures  = 0;
    logic  active    = 1'b0;

    logic                              model_busy;
    logic                              cap_done;
    logic                              capturing;
    logic                              thumb;
    logic                              fv_prev;
    logic                              lv_prev;
    int                                skip_left;
    int                                s_cyc;
    int                                cyc;
    int                                hdr_idx;
    int                                n_cmp;
    int                                x;
    int                                y;
    logic [HEADER_WORDS*WORD_BITS-1:0] hdr_q;
    logic [WORD_BITS-1:0]              exp_w;
    logic [WORD_BITS-1:0]              got_w;
    logic [PIXEL_BITS-1:0]             frame_pix [FRAME_W*FRAME_H];
    logic [WORD_BITS-1:0]              exp_q [$];
    logic [WORD_BITS-1:0]              got_q [$];

    function automatic void report_mismatch(input string name, input string what,
                                            input logic [WORD_BITS-1:0] expected,
                                            input logic [WORD_BITS-1:0] actual);
        errors++;
        $display("** Error [%s] %s: expected %04h, actual %04h", name, what, expected, actual);
    endfunction

    // ==================================================
    // Reference model of one capture
    // ==================================================
    // Pixel words of the recorded frame, then highlight, shadow, sum1, sum2
    function automatic void build_expected(input logic thumb_mode, input int rows);
        logic [PIXEL_BITS-1:0] p;
        logic [WORD_BITS-1:0]  w;
        int highlight = 0;
        int shadow    = 0;
        int s1        = 0;
        int s2        = 0;
        for (int yy = 0; yy < rows; yy++) begin
            for (int xx = 0; xx < FRAME_W; xx++) begin
                p = frame_pix[yy*FRAME_W + xx];
                // Sample grid is every 4th pixel in both directions
                if ((xx % 4 == 0) && (yy % 4 == 0)) begin
                    if (p[11:5] == 7'h7F) begin
                        highlight++;
                    end
                    if (p[11:5] == 7'h00) begin
                        shadow++;
                    end
                end
                if (!thumb_mode || ((xx % 8 < 2) && (yy % 8 < 2))) begin
                    w = {p[7:0], 4'h0, p[11:8]};
                    exp_q.push_back(w);
                    s1 = (s1 + int'(w)) % 65535;
                    s2 = (s2 + s1) % 65535;
                end
            end
        end
        exp_q.push_back(16'(highlight));
        exp_q.push_back(16'(shadow));
        exp_q.push_back(16'(s1));
        exp_q.push_back(16'(s2));
    endfunction

    // ==================================================
    // Cycle by cycle watch of the DUT ports
    // ==================================================
    always @(posedge clk) begin
        if (!arst_n) begin
            active     = 1'b0;
            model_busy = 1'b0;
            cap_done   = 1'b0;
            capturing  = 1'b0;
            fv_prev    = 1'b0;
            lv_prev    = 1'b0;
            cyc        = 0;
            exp_q.delete();
            got_q.delete();
        end else begin
            if (busy !== model_busy) begin
                report_mismatch(test_name, $sformatf("busy in cycle %0d", cyc),
                                WORD_BITS'(model_busy), WORD_BITS'(busy));
            end

            // Header word k is due 1+k cycles after the start cycle
            if (active && (hdr_idx < HEADER_WORDS) && (cyc == s_cyc + 1 + hdr_idx)) begin
                exp_w = hdr_q[(HEADER_WORDS-1-hdr_idx)*WORD_BITS +: WORD_BITS];
                if (out.valid !== 1'b1) begin
                    errors++;
                    $display("Header word %0d missing in cycle %0d of test %s",
                             hdr_idx, cyc, cap_name);
                end else if (out.data !== exp_w) begin
                    report_mismatch(cap_name, $sformatf("header word %0d", hdr_idx),
                                    exp_w, out.data);
                end
                hdr_idx++;
            end else if (out.valid !== 1'b0) begin
                if (!active || (hdr_idx < HEADER_WORDS)) begin
                    errors++;
                    $display("Unexpected output word %04h in cycle %0d of test %s",
                             out.data, cyc, test_name);
                end else begin
                    got_q.push_back(out.data);
                end
            end

            // A start counts only while no capture is running
            if (start && !model_busy) begin
                active     = 1'b1;
                model_busy = 1'b1;
                cap_done   = 1'b0;
                capturing  = 1'b0;
                cap_name   = test_name;
                thumb      = cmd.thumb;
                skip_left  = int'(cmd.skip);
                hdr_q      = header;
                hdr_idx    = 0;
                n_cmp      = 0;
                s_cyc      = cyc;
                exp_q.delete();
                got_q.delete();
            end

            // Frames rising from the last header word on are counted
            if (active && !cap_done && !capturing && img.fv && !fv_prev &&
                (cyc >= s_cyc + HEADER_WORDS)) begin
                if (skip_left > 0) begin
                    skip_left--;
                end else begin
                    capturing = 1'b1;
                    x         = 0;
                    y         = 0;
                end
            end
            if (capturing) begin
                if (!img.fv) begin
                    capturing = 1'b0;
                    cap_done  = 1'b1;
                    build_expected(thumb, (y < FRAME_H) ? y : FRAME_H);
                end else if (img.lv) begin
                    if ((x < FRAME_W) && (y < FRAME_H)) begin
                        frame_pix[y*FRAME_W + x] = img.d;
                    end
                    x++;
                end else if (lv_prev) begin
                    x = 0;
                    y++;
                end
            end

            while ((exp_q.size() > 0) && (got_q.size() > 0)) begin
                exp_w = exp_q.pop_front();
                got_w = got_q.pop_front();
                if (got_w !== exp_w) begin
                    report_mismatch(cap_name,
                                    $sformatf("output word %0d", HEADER_WORDS + n_cmp),
                                    exp_w, got_w);
                end
                n_cmp++;
            end
            // Busy drops the cycle after the last trailer word
            if (cap_done && (exp_q.size() == 0)) begin
                if (got_q.size() > 0) begin
                    errors++;
                    $display("%0d extra output words after the trailer of test %s",
                             got_q.size(), cap_name);
                    got_q.delete();
                end
                active     = 1'b0;
                model_busy = 1'b0;
                cap_done   = 1'b0;
                captures++;
            end

            fv_prev = img.fv;
            lv_prev = img.lv;
            cyc++;
        end
    end

endmodule

`default_nettype wire

// File: verification/tb_img_capture.sv
`default_nettype none

module tb_img_capture
    import img_pkg::*;
();

    localparam int HEADER_WORDS = 4;
    localparam int FRAME_W      = 16;
    localparam int FRAME_H      = 12;
    localparam int LINE_GAP     = 4;
    localparam int FRAME_GAP    = 6;
    localparam int RESET_CYCLES = 8;
    localparam int FRAME_CYCLES = FRAME_H * (FRAME_W + LINE_GAP) + FRAME_GAP;
    localparam int NUM_FRAMES   = 8;
    localparam int NUM_TESTS    = 5;
    // Start pulse, arming gap and trailer drain of one test
    localparam int TEST_CYCLES  = 40;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + 8 + NUM_FRAMES * FRAME_CYCLES
                                  + NUM_TESTS * TEST_CYCLES + 200;

    logic                              clk = 1'b0;
    logic                              arst_n;
    logic                              start;
    capture_cmd_t                      cmd;
    logic [HEADER_WORDS*WORD_BITS-1:0] header;
    pixel_in_t                         img;
    readout_t                          out;
    logic                              busy;
    integer                            seed = 32'h5242;
    int                                cycle_count = 0;
    int                                tb_errors = 0;

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    img_capture_top #(
        .HEADER_WORDS (HEADER_WORDS)
    ) u_dut (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (start),
        .cmd    (cmd),
        .header (header),
        .img    (img),
        .out    (out),
        .busy   (busy)
    );

    img_checker #(
        .HEADER_WORDS (HEADER_WORDS),
        .FRAME_W      (FRAME_W),
        .FRAME_H      (FRAME_H)
    ) u_chk (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (start),
        .cmd    (cmd),
        .header (header),
        .img    (img),
        .out    (out),
        .busy   (busy)
    );

    // ==================================================
    // Stimulus tasks
    // ==================================================
    task automatic drive_cycle(input logic fv, input logic lv, input logic [PIXEL_BITS-1:0] d);
        @(posedge clk);
        start <= 1'b0;
        img   <= '{fv: fv, lv: lv, d: d};
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            drive_cycle(1'b0, 1'b0, '0);
        end
    endtask

    task automatic pulse_start(input logic [SKIP_BITS-1:0] skip, input logic thumb,
                               input logic [HEADER_WORDS*WORD_BITS-1:0] hdr);
        @(posedge clk);
        start  <= 1'b1;
        cmd    <= '{skip: skip, thumb: thumb};
        header <= hdr;
    endtask

    // Style 1 forces lines 0 and 8 of each block to highlight, line 4 to shadow
    function automatic logic [PIXEL_BITS-1:0] pixel_value(input int y, input int style);
        logic [PIXEL_BITS-1:0] r;
        r = PIXEL_BITS'($random(seed));
        if ((style == 1) && (y % 8 == 0)) begin
            return r | 12'hFE0;
        end else if ((style == 1) && (y % 8 == 4)) begin
            return r & 12'h01F;
        end
        return r;
    endfunction

    task automatic send_frame(input int style);
        for (int y = 0; y < FRAME_H; y++) begin
            for (int x = 0; x < FRAME_W; x++) begin
                drive_cycle(1'b1, 1'b1, pixel_value(y, style));
            end
            repeat (LINE_GAP) begin
                drive_cycle(1'b1, 1'b0, '0);
            end
        end
        idle_cycles(FRAME_GAP);
    endtask

    task automatic wait_capture_end();
        @(negedge clk);
        while (u_chk.active) begin
            @(negedge clk);
        end
        idle_cycles(4);
    endtask

    task automatic run_capture(input string name, input logic [SKIP_BITS-1:0] skip,
                               input logic thumb, input logic [HEADER_WORDS*WORD_BITS-1:0] hdr,
                               input int style);
        u_chk.test_name = name;
        pulse_start(skip, thumb, hdr);
        idle_cycles(8);
        repeat (int'(skip) + 1) begin
            send_frame(style);
        end
        wait_capture_end();
    endtask

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        arst_n = 1'b0;
        start  = 1'b0;
        cmd    = '0;
        header = '0;
        img    = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        // Output must stay quiet until the first start
        idle_cycles(8);

        run_capture("full_frame", 2'd0, 1'b0, 64'h1111_2222_3333_4444, 0);
        // Tone lines put highlight and shadow samples outside the kept 2x2 blocks
        run_capture("thumbnail", 2'd0, 1'b1, 64'hA5A5_0001_5A5A_0002, 1);
        run_capture("skip_two", 2'd2, 1'b0, 64'h0F0F_F0F0_1234_5678, 0);
        run_capture("tone_lines", 2'd0, 1'b0, 64'hCAFE_0000_FFFF_0101, 1);

        // Frame rises inside the header, then a second start arrives while busy
        u_chk.test_name = "busy_start";
        pulse_start(2'd0, 1'b0, 64'h7777_8888_9999_AAAA);
        send_frame(0);
        pulse_start(2'd1, 1'b1, 64'hDEAD_BEEF_0BAD_F00D);
        idle_cycles(4);
        send_frame(0);
        wait_capture_end();

        if (u_chk.captures != NUM_TESTS) begin
            $display("Only %0d of %0d captures completed", u_chk.captures, NUM_TESTS);
            tb_errors++;
        end
        $display("Checks done: %0d errors over %0d captures", u_chk.errors + tb_errors,
                 u_chk.captures);
        if (u_chk.errors + tb_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        wait (cycle_count >= CYCLE_LIMIT);
        $display("Timeout after %0d cycles, a capture did not complete", cycle_count);
        $display("Errors before the timeout: %0d", u_chk.errors + tb_errors);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
